// ==== Makefile ====
.PHONY: run clean

run: obj_dir/Vexec_tb
	./obj_dir/Vexec_tb +verilator+error+limit+100 2>&1 | tee sim.log
	! grep -q "sim failed" sim.log
	grep -q "sim passed" sim.log

obj_dir/Vexec_tb: sim.f $(wildcard design/*.sv dv/*.sv)
	verilator --binary --timing --assert --top-module exec_tb -f sim.f

clean:
	rm -rf obj_dir sim.log

// ==== design/exec_alu.sv ====
`timescale 1ns/1ps

module exec_alu import exec_pkg::*; (
    input  exec_op_e        op,
    input  logic [XLEN-1:0] src_a,
    input  logic [XLEN-1:0] src_b,
    input  logic [XLEN-1:0] imm,
    input  logic            use_imm,
    output logic [XLEN-1:0] result,
    output logic            overflow
);

    localparam int SH_W = $clog2(XLEN);

    logic [XLEN-1:0] opb;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] addr;
    logic [SH_W-1:0] shamt;

    function automatic logic [XLEN-1:0] lead_zeros(input logic [XLEN-1:0] value);
        logic [XLEN-1:0] count;
        logic            found;
        count = '0;
        found = 1'b0;
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (value[i])
                found = 1'b1;
            else if (!found)
                count = count + 1'b1;
        end
        return count;
    endfunction

    assign opb   = use_imm ? imm : src_b;
    assign sum   = src_a + opb;
    assign diff  = src_a - opb;
    assign addr  = src_a + imm;

    // Shifts move src_a by the low bits of the second operand.
    assign shamt = opb[SH_W-1:0];

    always_comb begin
        case (op)
            ADD:     result = sum;
            SUB:     result = diff;
            AND:     result = src_a & opb;
            OR:      result = src_a | opb;
            XOR:     result = src_a ^ opb;
            SLT:     result = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(opb)};
            SLL:     result = src_a << shamt;
            SRL:     result = src_a >> shamt;
            LUI:     result = {opb[XLEN/2-1:0], {(XLEN/2){1'b0}}};
            CLZ:     result = lead_zeros(src_a);
            CLO:     result = lead_zeros(~src_a);
            default: result = is_mem(op) ? addr : '0;
        endcase
    end

    // Signed overflow shows as a sign flip that the operand signs do not allow.
    always_comb begin
        case (op)
            ADD:     overflow = (src_a[XLEN-1] == opb[XLEN-1]) && (sum[XLEN-1] != src_a[XLEN-1]);
            SUB:     overflow = (src_a[XLEN-1] != opb[XLEN-1]) && (diff[XLEN-1] != src_a[XLEN-1]);
            default: overflow = 1'b0;
        endcase
    end

endmodule

// ==== design/exec_forward.sv ====
`timescale 1ns/1ps

module exec_forward import exec_pkg::*; (
    input  logic [REG_W-1:0] rs_num,
    input  logic [REG_W-1:0] rt_num,
    input  logic [XLEN-1:0]  rs_data,
    input  logic [XLEN-1:0]  rt_data,
    input  logic             e_valid,
    input  logic             e_wr_en,
    input  logic [REG_W-1:0] e_reg,
    input  logic [XLEN-1:0]  e_data,
    input  logic             m_wr_en,
    input  logic [REG_W-1:0] m_reg,
    input  logic [XLEN-1:0]  m_data,
    output logic [XLEN-1:0]  src_a,
    output logic [XLEN-1:0]  src_b
);

    // The youngest producer wins. Register 0 always reads as the register file value.
    function automatic logic [XLEN-1:0] bypass(input logic [REG_W-1:0] num,
                                               input logic [XLEN-1:0]  rf_data);
        if (num == '0)
            return rf_data;
        if (e_valid && e_wr_en && e_reg == num)
            return e_data;
        if (m_wr_en && m_reg == num)
            return m_data;
        return rf_data;
    endfunction

    always_comb begin
        src_a = bypass(rs_num, rs_data);
        src_b = bypass(rt_num, rt_data);
    end

endmodule

// ==== design/exec_mem_ctrl.sv ====
`timescale 1ns/1ps

module exec_mem_ctrl import exec_pkg::*; (
    input  logic            Clk,
    input  logic            reset,
    input  exec_op_e        op,
    input  logic [1:0]      addr_low,
    input  logic            commit,
    output logic [BE_W-1:0] byte_en,
    output logic            unaligned,
    output logic            link_ok
);

    logic            link_bit;
    logic [BE_W-1:0] lanes;

    always_comb begin
        lanes     = '0;
        unaligned = 1'b0;
        case (op)
            LW, SW, LL, SC: begin
                lanes     = '1;
                unaligned = (addr_low != 2'b00);
            end
            LH, SH: begin
                lanes     = BE_W'(2'b11) << addr_low;
                unaligned = addr_low[0];
            end
            LB, SB: begin
                lanes     = BE_W'(1'b1) << addr_low;
            end
            default: begin
                lanes     = '0;
            end
        endcase
    end

    // A failed SC must not reach memory, so it loses its lanes like a misaligned access.
    assign byte_en = (unaligned || (op == SC && !link_bit)) ? '0 : lanes;
    assign link_ok = link_bit;

    always_ff @(posedge Clk) begin
        if (reset) begin
            link_bit <= 1'b0;
        end else if (commit && op == LL) begin
            link_bit <= 1'b1;
        end else if (commit && op == SC) begin
            link_bit <= 1'b0;
        end
    end

endmodule

// ==== design/exec_mul.sv ====
`timescale 1ns/1ps

module exec_mul import exec_pkg::*; #(
    parameter int MUL_BITS_PER_CYCLE = 4
) (
    input  logic            Clk,
    input  logic            reset,
    input  logic            start,
    input  logic            flush,
    input  logic            hold,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] product,
    output logic            mul_busy
);

    localparam int MUL_STEPS = XLEN / MUL_BITS_PER_CYCLE;
    localparam int CNT_W     = $clog2(MUL_STEPS + 1);

    logic             running;
    logic [CNT_W-1:0] step_cnt;
    logic             done;
    logic [XLEN-1:0]  acc;
    logic [XLEN-1:0]  mcand;
    logic [XLEN-1:0]  mplier;
    logic [XLEN-1:0]  partial;

    assign done = (step_cnt == CNT_W'(MUL_STEPS));

    // Once all steps are retired the unit stays busy only while the consumer holds.
    assign mul_busy = running && (!done || hold);
    assign product  = acc;

    // Sum of the shifted multiplicand copies selected by this step's multiplier bits.
    always_comb begin
        partial = '0;
        for (int i = 0; i < MUL_BITS_PER_CYCLE; i++) begin
            if (mplier[i])
                partial = partial + (mcand << i);
        end
    end

    always_ff @(posedge Clk) begin
        if (reset || flush) begin
            running  <= 1'b0;
            step_cnt <= '0;
        end else if (start) begin
            running  <= 1'b1;
            step_cnt <= '0;
        end else if (running && !done) begin
            step_cnt <= step_cnt + 1'b1;
        end else if (running && !hold) begin
            running  <= 1'b0;
        end
    end

    always_ff @(posedge Clk) begin
        if (start) begin
            acc    <= '0;
            mcand  <= a;
            mplier <= b;
        end else if (running && !done) begin
            acc    <= acc + partial;
            mcand  <= mcand << MUL_BITS_PER_CYCLE;
            mplier <= mplier >> MUL_BITS_PER_CYCLE;
        end
    end

endmodule

// ==== design/exec_pkg.sv ====
package exec_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 5;

    // One byte enable per lane of a data word.
    localparam int BE_W  = XLEN / 8;

    // A multiply takes XLEN / MUL_BITS_PER_CYCLE steps.
    // That count depends on the multiplier parameter, so exec_mul derives it locally.

    typedef enum logic [4:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLL,
        SRL,
        LUI,
        CLZ,
        CLO,
        MUL,
        LW,
        LH,
        LB,
        SW,
        SH,
        SB,
        LL,
        SC
    } exec_op_e;

    // Loads, stores and the LL/SC pair all carry an address in the result field.
    function automatic logic is_mem(input exec_op_e op);
        return op inside {LW, LH, LB, SW, SH, SB, LL, SC};
    endfunction

endpackage

// ==== design/exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage import exec_pkg::*; #(
    parameter int MUL_BITS_PER_CYCLE = 4
) (
    input  logic             Clk,
    input  logic             reset,
    input  logic             in_valid,
    input  exec_op_e         in_op,
    input  logic [XLEN-1:0]  in_pc,
    input  logic [REG_W-1:0] rs_num,
    input  logic [REG_W-1:0] rt_num,
    input  logic [XLEN-1:0]  rs_data,
    input  logic [XLEN-1:0]  rt_data,
    input  logic [XLEN-1:0]  imm,
    input  logic             use_imm,
    input  logic [REG_W-1:0] dest_reg,
    input  logic             wr_en,
    input  logic             m_wr_en,
    input  logic [REG_W-1:0] m_reg,
    input  logic [XLEN-1:0]  m_data,
    input  logic             mem_stall,
    input  logic             flush,
    output logic             out_valid,
    output logic [XLEN-1:0]  out_pc,
    output exec_op_e         out_op,
    output logic             out_wr_en,
    output logic [REG_W-1:0] out_reg,
    output logic [XLEN-1:0]  out_data,
    output logic [XLEN-1:0]  out_store_data,
    output logic [BE_W-1:0]  out_byte_en,
    output logic             out_overflow,
    output logic             out_unaligned,
    output logic             out_link_ok,
    output logic             busy
);

    logic [XLEN-1:0]  src_a;
    logic [XLEN-1:0]  src_b;
    logic [XLEN-1:0]  alu_result;
    logic             alu_overflow;
    logic [XLEN-1:0]  product;
    logic             mul_busy;
    logic [BE_W-1:0]  byte_en;
    logic             unaligned;
    logic             link_ok;
    logic             accept;
    logic             mul_start;
    logic             mul_done;
    logic             slot_valid;
    logic [XLEN-1:0]  slot_pc;
    logic [REG_W-1:0] slot_reg;
    logic             slot_wr_en;

    assign accept    = in_valid && !mem_stall && !flush;
    assign mul_start = accept && in_op == MUL;
    assign mul_done  = slot_valid && !mul_busy;
    assign busy      = slot_valid;

    exec_forward exec_forward_i (
        .rs_num  (rs_num),
        .rt_num  (rt_num),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .e_valid (out_valid),
        .e_wr_en (out_wr_en),
        .e_reg   (out_reg),
        .e_data  (out_data),
        .m_wr_en (m_wr_en),
        .m_reg   (m_reg),
        .m_data  (m_data),
        .src_a   (src_a),
        .src_b   (src_b)
    );

    exec_alu exec_alu_i (
        .op       (in_op),
        .src_a    (src_a),
        .src_b    (src_b),
        .imm      (imm),
        .use_imm  (use_imm),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    exec_mul #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) exec_mul_i (
        .Clk      (Clk),
        .reset    (reset),
        .start    (mul_start),
        .flush    (flush),
        .hold     (mem_stall),
        .a        (src_a),
        .b        (src_b),
        .product  (product),
        .mul_busy (mul_busy)
    );

    exec_mem_ctrl exec_mem_ctrl_i (
        .Clk       (Clk),
        .reset     (reset),
        .op        (in_op),
        .addr_low  (alu_result[1:0]),
        .commit    (accept && in_op != MUL),
        .byte_en   (byte_en),
        .unaligned (unaligned),
        .link_ok   (link_ok)
    );

    // The multiply slot remembers where the product goes while the multiplier runs.
    always_ff @(posedge Clk) begin
        if (reset || flush) begin
            slot_valid <= 1'b0;
        end else if (mul_start) begin
            slot_valid <= 1'b1;
        end else if (mul_done && !mem_stall) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge Clk) begin
        if (mul_start) begin
            slot_pc    <= in_pc;
            slot_reg   <= dest_reg;
            slot_wr_en <= wr_en;
        end
    end

    // Loads and SC write back later than this stage, so they do not bypass from here.
    always_ff @(posedge Clk) begin
        if (reset || flush) begin
            out_valid     <= 1'b0;
            out_wr_en     <= 1'b0;
            out_byte_en   <= '0;
            out_overflow  <= 1'b0;
            out_unaligned <= 1'b0;
            out_link_ok   <= 1'b0;
        end else if (!mem_stall) begin
            if (mul_done) begin
                out_valid     <= 1'b1;
                out_wr_en     <= slot_wr_en;
                out_byte_en   <= '0;
                out_overflow  <= 1'b0;
                out_unaligned <= 1'b0;
                out_link_ok   <= 1'b0;
            end else begin
                out_valid     <= in_valid && in_op != MUL;
                out_wr_en     <= in_valid && wr_en && in_op != MUL && !is_mem(in_op);
                out_byte_en   <= in_valid ? byte_en : '0;
                out_overflow  <= in_valid && alu_overflow;
                out_unaligned <= in_valid && unaligned;
                out_link_ok   <= in_valid && in_op == SC && link_ok;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!mem_stall) begin
            if (mul_done) begin
                out_pc         <= slot_pc;
                out_op         <= MUL;
                out_reg        <= slot_reg;
                out_data       <= product;
                out_store_data <= '0;
            end else if (in_valid) begin
                out_pc         <= in_pc;
                out_op         <= in_op;
                out_reg        <= dest_reg;
                out_data       <= alu_result;
                out_store_data <= src_b;
            end
        end
    end

endmodule

// ==== dv/exec_checker.sv ====
`timescale 1ns/1ps

module exec_checker import exec_pkg::*; (
    input logic            Clk,
    input logic            reset,
    input logic            in_valid,
    input logic            busy,
    input logic            mem_stall,
    input logic            flush,
    input logic            out_valid,
    input logic            out_unaligned,
    input logic [BE_W-1:0] out_byte_en
);

    int fail_count = 0;

    // Decode may only issue while the stage can take a new instruction.
    no_issue_while_blocked: assert property (
        @(posedge Clk) disable iff (reset) !(in_valid && (busy || mem_stall)))
        else begin
            $error("in_valid was raised while busy or mem_stall was high");
            fail_count++;
        end

    flush_empties_stage: assert property (
        @(posedge Clk) disable iff (reset) flush |=> !out_valid)
        else begin
            $error("out_valid was still high in the cycle after a flush");
            fail_count++;
        end

    // A misaligned access must never reach memory.
    unaligned_has_no_lanes: assert property (
        @(posedge Clk) disable iff (reset) out_unaligned |-> out_byte_en == '0)
        else begin
            $error("out_byte_en was not zero for a misaligned access");
            fail_count++;
        end

endmodule

bind exec_stage exec_checker checker_i (
    .Clk           (Clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .busy          (busy),
    .mem_stall     (mem_stall),
    .flush         (flush),
    .out_valid     (out_valid),
    .out_unaligned (out_unaligned),
    .out_byte_en   (out_byte_en)
);

// ==== dv/exec_tb.sv ====
`timescale 1ns/1ps

module exec_tb import exec_pkg::*; ();

    // The DUT runs with its default multiplier width.
    localparam int MUL_BITS_PER_CYCLE = 4;
    localparam int MUL_STEPS          = XLEN / MUL_BITS_PER_CYCLE;

    logic             Clk;
    logic             reset;
    logic             in_valid;
    exec_op_e         in_op;
    logic [XLEN-1:0]  in_pc;
    logic [REG_W-1:0] rs_num;
    logic [REG_W-1:0] rt_num;
    logic [XLEN-1:0]  rs_data;
    logic [XLEN-1:0]  rt_data;
    logic [XLEN-1:0]  imm;
    logic             use_imm;
    logic [REG_W-1:0] dest_reg;
    logic             wr_en;
    logic             m_wr_en;
    logic [REG_W-1:0] m_reg;
    logic [XLEN-1:0]  m_data;
    logic             mem_stall;
    logic             flush;
    logic             out_valid;
    logic [XLEN-1:0]  out_pc;
    exec_op_e         out_op;
    logic             out_wr_en;
    logic [REG_W-1:0] out_reg;
    logic [XLEN-1:0]  out_data;
    logic [XLEN-1:0]  out_store_data;
    logic [BE_W-1:0]  out_byte_en;
    logic             out_overflow;
    logic             out_unaligned;
    logic             out_link_ok;
    logic             busy;

    string            lines[$];
    int               cycles;
    int               limit = 0;
    logic [XLEN-1:0]  next_pc;

    // Expected contents of the output register as seen by the next instruction.
    logic             prev_wr;
    logic [REG_W-1:0] prev_reg;
    logic [XLEN-1:0]  prev_data;

    exec_stage exec_stage_i (.*);

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "Run aborted");
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [XLEN-1:0] expected,
                                   input logic [XLEN-1:0] actual);
        abort_run($sformatf("FAIL %s: %s expected 0x%0h, actual 0x%0h",
                            name, what, expected, actual));
    endtask

    function automatic logic op_lookup(input string op_name, output exec_op_e op);
        exec_op_e cand;
        cand = cand.first();
        op   = cand;
        for (int i = 0; i < cand.num(); i++) begin
            if (cand.name() == op_name) begin
                op = cand;
                return 1'b1;
            end
            cand = cand.next();
        end
        return 1'b0;
    endfunction

    // Operand value the stage should see, newest producer first and never for register 0.
    function automatic logic [XLEN-1:0] operand_value(input logic [REG_W-1:0] num,
                                                      input logic [XLEN-1:0]  rf_data,
                                                      input logic             mem_wen,
                                                      input logic [REG_W-1:0] mem_reg,
                                                      input logic [XLEN-1:0]  mem_data);
        if (num == '0)
            return rf_data;
        if (prev_wr && prev_reg == num)
            return prev_data;
        if (mem_wen && mem_reg == num)
            return mem_data;
        return rf_data;
    endfunction

    // Runs one vector. Time is 10 ns past a rising edge on entry and on return.
    task automatic run_test(input string text);
        string            name;
        string            mode;
        string            op_name;
        exec_op_e         op;
        int               fields;
        int               latency;
        int               exp_latency;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [REG_W-1:0] dst;
        logic [REG_W-1:0] mreg;
        logic [XLEN-1:0]  rsd;
        logic [XLEN-1:0]  rtd;
        logic [XLEN-1:0]  imm_v;
        logic [XLEN-1:0]  md;
        logic [XLEN-1:0]  exp_data;
        logic [XLEN-1:0]  exp_store;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  held;
        logic [BE_W-1:0]  exp_be;
        logic             uimm;
        logic             wen;
        logic             mwen;
        logic             exp_ovf;
        logic             exp_unal;
        logic             exp_link;
        logic             exp_wr_en;
        fields = $sscanf(text, "%s %s %s %d %d %h %h %h %d %d %d %d %d %h %h %h %d %d %d",
                         name, mode, op_name, rs, rt, rsd, rtd, imm_v, uimm, dst, wen,
                         mwen, mreg, md, exp_data, exp_be, exp_ovf, exp_unal, exp_link);
        if (fields != 19)
            abort_run({"Malformed line in the test file: ", text});
        if (!op_lookup(op_name, op))
            abort_run({"Unknown operation ", op_name, " in test ", name});
        if (mode != "normal" && mode != "stall" && mode != "flush")
            abort_run({"Unknown mode ", mode, " in test ", name});

        // Memory operations carry an address, so they never write back from this stage.
        exp_wr_en = wen && !(op inside {LW, LH, LB, SW, SH, SB, LL, SC});
        exp_store = operand_value(rt, rtd, mwen, mreg, md);

        pc       = next_pc;
        next_pc  = next_pc + 4;
        in_valid = 1'b1;
        in_op    = op;
        in_pc    = pc;
        rs_num   = rs;
        rt_num   = rt;
        rs_data  = rsd;
        rt_data  = rtd;
        imm      = imm_v;
        use_imm  = uimm;
        dest_reg = dst;
        wr_en    = wen;
        m_wr_en  = mwen;
        m_reg    = mreg;
        m_data   = md;
        @(posedge Clk);
        #10;
        in_valid = 1'b0;
        m_wr_en  = 1'b0;

        if (mode == "flush") begin
            assert (op != MUL || busy)
                else abort_run({"The multiply in ", name, " did not start before the flush"});
            flush = 1'b1;
            @(posedge Clk);
            #10;
            flush = 1'b0;
            assert (!out_valid && !busy)
                else abort_run({"The flush left a result or a busy multiply in ", name});
            repeat (MUL_STEPS + 2) begin
                @(posedge Clk);
                #10;
                assert (!out_valid)
                    else abort_run({"A result appeared after the flush in ", name});
            end
            prev_wr = 1'b0;
        end else begin
            latency = 1;
            while (!out_valid) begin
                assert (op == MUL && busy)
                    else abort_run({"No result and no busy multiply in ", name});
                @(posedge Clk);
                #10;
                latency++;
            end
            // The accepting edge is counted, and a product follows MUL_STEPS + 1 edges later.
            exp_latency = (op == MUL) ? MUL_STEPS + 2 : 1;
            assert (latency == exp_latency)
                else report_mismatch(name, "latency", exp_latency, latency);
            assert (!busy)
                else abort_run({"busy was still high with the result of ", name});
            assert (out_pc == pc)
                else report_mismatch(name, "out_pc", pc, out_pc);
            assert (out_op == op)
                else report_mismatch(name, "out_op", XLEN'(op), XLEN'(out_op));
            assert (out_reg == dst)
                else report_mismatch(name, "out_reg", XLEN'(dst), XLEN'(out_reg));
            assert (out_wr_en == exp_wr_en)
                else report_mismatch(name, "out_wr_en", XLEN'(exp_wr_en), XLEN'(out_wr_en));
            assert (out_data == exp_data)
                else report_mismatch(name, "out_data", exp_data, out_data);
            if (op != MUL) begin
                assert (out_store_data == exp_store)
                    else report_mismatch(name, "out_store_data", exp_store, out_store_data);
            end
            assert (out_byte_en == exp_be)
                else report_mismatch(name, "out_byte_en", XLEN'(exp_be), XLEN'(out_byte_en));
            assert (out_overflow == exp_ovf)
                else report_mismatch(name, "out_overflow", XLEN'(exp_ovf), XLEN'(out_overflow));
            assert (out_unaligned == exp_unal)
                else report_mismatch(name, "out_unaligned", XLEN'(exp_unal),
                                     XLEN'(out_unaligned));
            assert (out_link_ok == exp_link)
                else report_mismatch(name, "out_link_ok", XLEN'(exp_link), XLEN'(out_link_ok));

            if (mode == "stall") begin
                held      = out_data;
                mem_stall = 1'b1;
                repeat (3) begin
                    @(posedge Clk);
                    #10;
                    assert (out_valid && out_data == held)
                        else report_mismatch(name, "held out_data", held, out_data);
                end
                mem_stall = 1'b0;
            end
            prev_wr   = exp_wr_en;
            prev_reg  = dst;
            prev_data = exp_data;
        end
    endtask

    // A failed checker assertion ends the run at once.
    always @(exec_stage_i.checker_i.fail_count) begin
        if (exec_stage_i.checker_i.fail_count != 0)
            abort_run("A concurrent assertion in the checker failed");
    end

    // The run may last a fixed number of cycles per vector.
    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge Clk);
            cycles++;
        end
        abort_run($sformatf("Timeout: the run did not finish within %0d cycles", limit));
    end

    initial begin
        int    fd;
        string text;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_op     = ADD;
        in_pc     = '0;
        rs_num    = '0;
        rt_num    = '0;
        rs_data   = '0;
        rt_data   = '0;
        imm       = '0;
        use_imm   = 1'b0;
        dest_reg  = '0;
        wr_en     = 1'b0;
        m_wr_en   = 1'b0;
        m_reg     = '0;
        m_data    = '0;
        mem_stall = 1'b0;
        flush     = 1'b0;
        next_pc   = 32'h0040_0000;
        prev_wr   = 1'b0;
        prev_reg  = '0;
        prev_data = '0;

        fd = $fopen("dv/exec_tests.txt", "r");
        if (fd == 0)
            abort_run("Cannot open the test file dv/exec_tests.txt");
        while ($fgets(text, fd) > 0) begin
            if (text.len() > 1 && text[0] != "#")
                lines.push_back(text);
        end
        $fclose(fd);
        limit = lines.size() * (MUL_STEPS + 6) + 50;

        repeat (3) @(posedge Clk);
        #10;
        reset = 1'b0;

        foreach (lines[i])
            run_test(lines[i]);

        if (exec_stage_i.checker_i.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("Concurrent assertions in the checker failed");
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== dv/exec_tests.txt ====
# name mode op rs rt rs_data rt_data imm use_imm dest wr_en m_wr_en m_reg m_data
# exp_data exp_byte_en exp_overflow exp_unaligned exp_link_ok (data in hex, the rest decimal)
add_basic      normal ADD  1  2 00000005 00000007 00000000 0  0 0 0  0 00000000 0000000c 0 0 0 0
add_ovf        normal ADD  1  2 7fffffff 00000001 00000000 0  0 0 0  0 00000000 80000000 0 1 0 0
sub_ovf        normal SUB  1  2 80000000 00000001 00000000 0  0 0 0  0 00000000 7fffffff 0 1 0 0
subi_basic     normal SUB  1  2 00000010 00000000 00000003 1  0 0 0  0 00000000 0000000d 0 0 0 0
and_reg        normal AND  1  2 0f0f00ff 00ff0f0f 00000000 0  0 0 0  0 00000000 000f000f 0 0 0 0
or_no_ovf      normal OR   1  2 7fffffff 00000001 00000000 0  0 0 0  0 00000000 7fffffff 0 0 0 0
xori_ones      normal XOR  1  2 a5a5a5a5 00000000 ffffffff 1  0 0 0  0 00000000 5a5a5a5a 0 0 0 0
slt_neg        normal SLT  1  2 ffffffff 00000001 00000000 0  0 0 0  0 00000000 00000001 0 0 0 0
sll_31         normal SLL  1  2 00000001 0000001f 00000000 0  0 0 0  0 00000000 80000000 0 0 0 0
srli_4         normal SRL  1  2 80000000 00000000 00000004 1  0 0 0  0 00000000 08000000 0 0 0 0
lui_imm        normal LUI  1  2 00000000 00000000 00001234 1  0 0 0  0 00000000 12340000 0 0 0 0
clz_zero       normal CLZ  1  2 00000000 00000000 00000000 0  0 0 0  0 00000000 00000020 0 0 0 0
clz_ones       normal CLZ  1  2 ffffffff 00000000 00000000 0  0 0 0  0 00000000 00000000 0 0 0 0
clz_mid        normal CLZ  1  2 00010000 00000000 00000000 0  0 0 0  0 00000000 0000000f 0 0 0 0
clo_ones       normal CLO  1  2 ffffffff 00000000 00000000 0  0 0 0  0 00000000 00000020 0 0 0 0
clo_zero       normal CLO  1  2 00000000 00000000 00000000 0  0 0 0  0 00000000 00000000 0 0 0 0
fwd_setup      normal ADD  3  4 00000010 00000020 00000000 0  5 1 0  0 00000000 00000030 0 0 0 0
fwd_exec_first normal ADD  5  6 00000001 00000002 00000000 0  7 1 1  5 00000100 00000032 0 0 0 0
fwd_mem        normal ADD  9  6 00000001 00000002 00000000 0  0 1 1  9 00000100 00000102 0 0 0 0
fwd_r0         normal ADD  0  0 00000004 00000003 00000000 0  0 0 1  0 00000100 00000007 0 0 0 0
lw_ok          normal LW   1  2 00001000 00000000 00000004 1  8 1 0  0 00000000 00001004 f 0 0 0
lw_unaligned   normal LW   1  2 00001000 00000000 00000002 1  8 1 0  0 00000000 00001002 0 0 1 0
lh_upper       normal LH   1  2 00001000 00000000 00000002 1  8 1 0  0 00000000 00001002 c 0 0 0
lh_odd         normal LH   1  2 00001000 00000000 00000001 1  8 1 0  0 00000000 00001001 0 0 1 0
lb_lane3       normal LB   1  2 00001000 00000000 00000003 1  8 1 0  0 00000000 00001003 8 0 0 0
sb_lane1       normal SB   1  2 00001000 12345678 00000001 1  0 0 0  0 00000000 00001001 2 0 0 0
sh_lower       normal SH   1  2 00001000 12345678 00000000 1  0 0 0  0 00000000 00001000 3 0 0 0
sw_unaligned   normal SW   1  2 00001000 12345678 00000003 1  0 0 0  0 00000000 00001003 0 0 1 0
lw_neg_imm     normal LW   1  2 00001000 00000000 fffffffc 1  8 1 0  0 00000000 00000ffc f 0 0 0
ll_set         normal LL   1  2 00002000 00000000 00000000 1  8 1 0  0 00000000 00002000 f 0 0 0
sc_ok          normal SC   1  2 00002000 00000001 00000000 1  8 1 0  0 00000000 00002000 f 0 0 1
sc_fail        normal SC   1  2 00002000 00000001 00000000 1  8 1 0  0 00000000 00002000 0 0 0 0
mul_small      normal MUL  1  2 00000007 00000006 00000000 0  0 0 0  0 00000000 0000002a 0 0 0 0
mul_wrap       normal MUL  1  2 12345678 00000010 00000000 0  0 0 0  0 00000000 23456780 0 0 0 0
mul_ones       normal MUL  1  2 ffffffff ffffffff 00000000 0  0 0 0  0 00000000 00000001 0 0 0 0
ll_relink      normal LL   1  2 00002000 00000000 00000000 1  8 1 0  0 00000000 00002000 f 0 0 0
mul_flush      flush  MUL  1  2 00000003 00000003 00000000 0  0 0 0  0 00000000 00000000 0 0 0 0
sc_after_flush normal SC   1  2 00002000 00000001 00000000 1  8 1 0  0 00000000 00002000 f 0 0 1
add_stall      stall  ADD  1  2 00000011 00000022 00000000 0  0 0 0  0 00000000 00000033 0 0 0 0
mul_stall      stall  MUL  1  2 00000009 00000009 00000000 0  0 0 0  0 00000000 00000051 0 0 0 0

// ==== sim.f ====
design/exec_pkg.sv
design/exec_forward.sv
design/exec_alu.sv
design/exec_mul.sv
design/exec_mem_ctrl.sv
design/exec_stage.sv
dv/exec_checker.sv
dv/exec_tb.sv
